/* hdl/backing_ram.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module backing_ram (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     mem_req,
	input  logic                     mem_we,     // High for write-back
	input  logic [`CACHE_ADDR_W-1:0] mem_addr,
	input  logic [`CACHE_DATA_W-1:0] mem_wdata,
	output logic                     mem_ack,
	output logic [`CACHE_DATA_W-1:0] mem_rdata   // Valid while mem_ack high
);

	//////////////////////////////
	// Storage and delay
	//////////////////////////////

	logic [`CACHE_DATA_W-1:0]      mem_q [2**`CACHE_ADDR_W]; // One byte per address
	logic [$clog2(`MEM_LAT+1)-1:0] cnt_q;                    // Edges since mem_req seen
	logic                          fire;                     // Access happens this edge

	// Delay expired with the request still open
	assign fire = mem_req && !mem_ack && (int'(cnt_q) == `MEM_LAT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_ack <= 1'b0;
			cnt_q   <= '0;
			for (int i = 0; i < 2**`CACHE_ADDR_W; i++)
				mem_q[i] <= '0; // Memory starts zeroed
		end else begin
			if (fire) begin
				mem_ack <= 1'b1;
				cnt_q   <= '0;
				if (mem_we)
					mem_q[mem_addr] <= mem_wdata;
			end else if (mem_req && !mem_ack) begin
				cnt_q <= cnt_q + 1'b1;
			end else if (mem_ack && !mem_req) begin
				mem_ack <= 1'b0; // Close the handshake
			end
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Held with mem_ack until the next read
	always_ff @(posedge clk) begin
		if (fire && !mem_we)
			mem_rdata <= mem_q[mem_addr];
	end

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_ctrl import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	// Host side
	input  logic                     req,
	input  cache_op_t                op,
	input  logic [`CACHE_ADDR_W-1:0] addr,
	input  logic [`CACHE_DATA_W-1:0] wdata,
	output logic                     ack,
	output logic [`CACHE_DATA_W-1:0] rdata,
	output logic                     hit,
	// Memory side
	output logic                     mem_req,
	output logic                     mem_we,
	output logic [`CACHE_ADDR_W-1:0] mem_addr,
	output logic [`CACHE_DATA_W-1:0] mem_wdata,
	input  logic                     mem_ack,
	input  logic [`CACHE_DATA_W-1:0] mem_rdata,
	// Store lookup and victim
	input  logic                     lk_hit,
	input  way_idx_t                 lk_way,
	input  logic [`CACHE_DATA_W-1:0] lk_data,
	input  logic                     vic_valid,
	input  logic                     vic_dirty,
	input  logic [`CACHE_ADDR_W-1:0] vic_tag,
	input  logic [`CACHE_DATA_W-1:0] vic_data,
	// Store write
	output logic                     wr_en,
	output way_idx_t                 wr_way,
	output logic [`CACHE_ADDR_W-1:0] wr_tag,
	output logic [`CACHE_DATA_W-1:0] wr_data,
	output logic                     wr_dirty,
	// LRU
	output logic                     touch,
	output way_idx_t                 touch_way,
	input  way_idx_t                 victim_way
);

	typedef enum logic [2:0] {
		S_IDLE,    // Wait for req
		S_LOOKUP,  // Store answers for the registered request
		S_MEM,     // mem_req high, waiting on mem_ack
		S_MEM_END, // mem_req dropped, waiting for mem_ack to fall
		S_ACK      // Hold ack until req falls
	} state_t;

	state_t                   state_q;
	cache_op_t                op_q;
	logic [`CACHE_ADDR_W-1:0] addr_q;
	logic [`CACHE_DATA_W-1:0] wdata_q;
	way_idx_t                 vic_q;   // Way being replaced on a miss
	logic                     wb_q;    // Current memory transaction is a write-back
	logic                     in_lookup;
	logic                     vic_wb;  // Victim must go back to memory
	logic                     hit_write;
	logic                     miss_install;
	logic                     fill_done;
	logic                     wb_install;

	//////////////////////////////
	// Store and LRU controls
	//////////////////////////////

	assign in_lookup = (state_q == S_LOOKUP);
	assign vic_wb    = vic_valid && vic_dirty;

	assign hit_write    = in_lookup && lk_hit && (op_q == OP_WRITE);
	assign miss_install = in_lookup && !lk_hit && (op_q == OP_WRITE) && !vic_wb; // No memory trip
	assign fill_done    = (state_q == S_MEM) && mem_ack && !wb_q;                // Read data on the bus
	assign wb_install   = (state_q == S_MEM_END) && !mem_ack && wb_q && (op_q == OP_WRITE);

	assign wr_en    = hit_write || miss_install || fill_done || wb_install;
	assign wr_way   = in_lookup ? (lk_hit ? lk_way : victim_way) : vic_q;
	assign wr_tag   = addr_q;
	assign wr_data  = fill_done ? mem_rdata : wdata_q;
	assign wr_dirty = !fill_done; // Only a fill matches memory

	// Read hits refresh recency too
	assign touch     = (in_lookup && lk_hit) || wr_en;
	assign touch_way = wr_way;

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= S_IDLE;
			ack     <= 1'b0;
			hit     <= 1'b0;
			mem_req <= 1'b0;
			mem_we  <= 1'b0;
			wb_q    <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (req)
						state_q <= S_LOOKUP;
				end
				S_LOOKUP: begin
					hit <= lk_hit; // Residency at arrival
					if (lk_hit || miss_install) begin
						ack     <= 1'b1;
						state_q <= S_ACK;
					end else begin
						mem_req <= 1'b1;
						mem_we  <= vic_wb;  // Write-back first, otherwise straight to fill
						wb_q    <= vic_wb;
						state_q <= S_MEM;
					end
				end
				S_MEM: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						state_q <= S_MEM_END;
					end
				end
				S_MEM_END: begin
					if (!mem_ack) begin
						if (wb_q && (op_q == OP_READ)) begin
							mem_req <= 1'b1; // Victim saved, now fetch the line
							mem_we  <= 1'b0;
							wb_q    <= 1'b0;
							state_q <= S_MEM;
						end else begin
							ack     <= 1'b1;
							state_q <= S_ACK;
						end
					end
				end
				S_ACK: begin
					if (!req) begin
						ack     <= 1'b0;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Request and bus payload
	//////////////////////////////

	always_ff @(posedge clk) begin
		if ((state_q == S_IDLE) && req) begin
			op_q    <= op;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
		if (in_lookup) begin
			vic_q     <= victim_way;
			mem_addr  <= vic_wb ? vic_tag : addr_q;
			mem_wdata <= vic_data;
			if (lk_hit)
				rdata <= lk_data;
		end
		if ((state_q == S_MEM_END) && !mem_ack)
			mem_addr <= addr_q; // Fill address after a write-back
		if (fill_done)
			rdata <= mem_rdata;
	end

	// RAM has to close the previous handshake first
	a_mem_req_rise : assert property (@(posedge clk) disable iff (!arst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("cache_ctrl: mem_req raised while mem_ack high");

	a_ack_needs_req : assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> req)
		else $error("cache_ctrl: ack raised without req");

endmodule

/* hdl/cache_lru.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_lru import cache_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`CACHE_WAYS-1:0] valid_vec,  // From the store
	input  logic                   touch,      // One cycle per access
	input  way_idx_t               touch_way,
	output way_idx_t               victim_way
);

	//////////////////////////////
	// Age counters
	//////////////////////////////

	// 3 is most recent, 0 is next to go
	logic [1:0] age_q [`CACHE_WAYS];
	way_idx_t   inv_way; // Lowest empty way
	way_idx_t   old_way; // Way with age 0
	logic       any_inv;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CACHE_WAYS; i++)
				age_q[i] <= 2'd0;
		end else if (touch) begin
			for (int i = 0; i < `CACHE_WAYS; i++) begin
				if (way_idx_t'(i) == touch_way)
					age_q[i] <= 2'd3;                  // Becomes MRU
				else if (age_q[i] > age_q[touch_way])
					age_q[i] <= age_q[i] - 2'd1;       // Newer than the touched way, slides down
			end
		end
	end

	//////////////////////////////
	// Victim select
	//////////////////////////////

	// Scan from the top so the lowest index wins
	always_comb begin
		inv_way = '0;
		old_way = '0;
		for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
			if (!valid_vec[i])
				inv_way = way_idx_t'(i);
			if (age_q[i] == 2'd0)
				old_way = way_idx_t'(i);
		end
	end

	assign any_inv    = ~&valid_vec;
	assign victim_way = any_inv ? inv_way : old_way; // Empty ways before eviction

	// Holds only while every fill lands in an empty or age-0 way
	for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_age_i
		for (genvar j = i + 1; j < `CACHE_WAYS; j++) begin : g_age_j
			a_age_distinct : assert property (@(posedge clk) disable iff (!arst_n)
				(valid_vec[i] && valid_vec[j]) |-> (age_q[i] != age_q[j]))
				else $error("cache_lru: ways %0d and %0d share age %0d", i, j, age_q[i]);
		end
	end

endmodule

/* hdl/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

	//////////////////////////////
	// Host access kind
	//////////////////////////////

	typedef enum logic {
		OP_READ  = 1'b0, // Load from cache
		OP_WRITE = 1'b1  // Store into cache
	} cache_op_t;

	//////////////////////////////
	// Way select
	//////////////////////////////

	// Wide enough to name any one way
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_idx_t;

endpackage

/* hdl/cache_store.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_store import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	// Lookup side
	input  logic [`CACHE_ADDR_W-1:0] addr,      // Host address, compared on every way
	input  way_idx_t                 way,       // Victim way picked by the LRU
	// Write side
	input  logic                     wr_en,
	input  way_idx_t                 wr_way,
	input  logic [`CACHE_ADDR_W-1:0] wr_tag,
	input  logic [`CACHE_DATA_W-1:0] wr_data,
	input  logic                     wr_dirty,
	// Lookup result
	output logic                     lk_hit,
	output way_idx_t                 lk_way,
	output logic [`CACHE_DATA_W-1:0] lk_data,
	output logic [`CACHE_WAYS-1:0]   valid_vec,
	// Victim line
	output logic                     vic_valid,
	output logic                     vic_dirty,
	output logic [`CACHE_ADDR_W-1:0] vic_tag,
	output logic [`CACHE_DATA_W-1:0] vic_data
);

	//////////////////////////////
	// Line storage
	//////////////////////////////

	logic [`CACHE_ADDR_W-1:0] tag_q  [`CACHE_WAYS]; // Full address is the tag
	logic [`CACHE_DATA_W-1:0] data_q [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0]   valid_q;
	logic [`CACHE_WAYS-1:0]   dirty_q;             // Line differs from backing RAM
	logic [`CACHE_WAYS-1:0]   match;               // One bit per way

	// Tag and data only mean something once valid is set
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[wr_way]  <= wr_tag;
			data_q[wr_way] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0; // All ways empty
			dirty_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_way] <= 1'b1;     // Any write installs the line
			dirty_q[wr_way] <= wr_dirty; // Fill is clean, host write is dirty
		end
	end

	//////////////////////////////
	// Parallel tag compare
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == addr);
		end
	end

	// Encode the matching way
	always_comb begin
		lk_way = '0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (match[i])
				lk_way = way_idx_t'(i);
		end
	end

	assign lk_hit    = |match;
	assign lk_data   = data_q[lk_way]; // Don't care on a miss
	assign valid_vec = valid_q;        // LRU fills empty ways first

	// Victim line for write-back
	assign vic_valid = valid_q[way];
	assign vic_dirty = dirty_q[way];
	assign vic_tag   = tag_q[way];
	assign vic_data  = data_q[way];

	// Controller only installs on a miss, so an address lives in one way at most
	a_unique_tag : assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(match))
		else $error("cache_store: address %h resident in more than one way", addr);

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_top import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     req,
	input  cache_op_t                op,
	input  logic [`CACHE_ADDR_W-1:0] addr,
	input  logic [`CACHE_DATA_W-1:0] wdata,
	output logic                     ack,
	output logic [`CACHE_DATA_W-1:0] rdata,
	output logic                     hit
);

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Store to controller
	logic                     lk_hit;
	way_idx_t                 lk_way;
	logic [`CACHE_DATA_W-1:0] lk_data;
	logic [`CACHE_WAYS-1:0]   valid_vec;
	logic                     vic_valid;
	logic                     vic_dirty;
	logic [`CACHE_ADDR_W-1:0] vic_tag;
	logic [`CACHE_DATA_W-1:0] vic_data;
	// Controller to store
	logic                     wr_en;
	way_idx_t                 wr_way;
	logic [`CACHE_ADDR_W-1:0] wr_tag;
	logic [`CACHE_DATA_W-1:0] wr_data;
	logic                     wr_dirty;
	// LRU
	logic                     touch;
	way_idx_t                 touch_way;
	way_idx_t                 victim_way;
	// Memory bus
	logic                     mem_req;
	logic                     mem_we;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	logic [`CACHE_DATA_W-1:0] mem_wdata;
	logic                     mem_ack;
	logic [`CACHE_DATA_W-1:0] mem_rdata;

	cache_ctrl i_ctrl (.*);

	// Lookup runs on the live host address, held stable while req is high
	cache_store i_store (
		.clk, .arst_n, .addr, .way(victim_way),
		.wr_en, .wr_way, .wr_tag, .wr_data, .wr_dirty,
		.lk_hit, .lk_way, .lk_data, .valid_vec,
		.vic_valid, .vic_dirty, .vic_tag, .vic_data
	);

	cache_lru i_lru (.clk, .arst_n, .valid_vec, .touch, .touch_way, .victim_way);

	backing_ram i_ram (
		.clk, .arst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata,
		.mem_ack, .mem_rdata
	);

endmodule

/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

//////////////////////////////
// Cache geometry
//////////////////////////////

`define CACHE_ADDR_W 8 // Host and memory address bits
`define CACHE_DATA_W 8 // One byte per line
`define CACHE_WAYS   4 // Fully associative, all ways searched at once

//////////////////////////////
// Backing memory timing
//////////////////////////////

`define MEM_LAT 3 // Edges from first seen mem_req to mem_ack

`endif

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and grep the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_cache_top -f src.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_cache_top > sim.log 2>&1 \
	|| echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
exit 0

/* src.f */
+incdir+include
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_lru.sv
hdl/cache_ctrl.sv
hdl/backing_ram.sv
hdl/cache_top.sv
verif/tb_cache_top.sv

/* verif/tb_cache_top.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module tb_cache_top import cache_pkg::*; ();

	localparam int ACK_TIMEOUT = 200; // Worst miss is two RAM trips, far below this
	localparam int HIT_CYCLES  = 3;   // Negedges from driving req to seeing ack on a hit

	logic                     clk;
	logic                     arst_n;
	logic                     req;
	cache_op_t                op;
	logic [`CACHE_ADDR_W-1:0] addr;
	logic [`CACHE_DATA_W-1:0] wdata;
	logic                     ack;
	logic [`CACHE_DATA_W-1:0] rdata;
	logic                     hit;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	logic [`CACHE_DATA_W-1:0] model_mem [2**`CACHE_ADDR_W]; // Host view of every byte
	logic [`CACHE_ADDR_W-1:0] recent [$];                   // Resident lines, front is LRU
	logic                     ack_prev = 1'b0;

	cache_top i_dut (.clk, .arst_n, .req, .op, .addr, .wdata, .ack, .rdata, .hit);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %s: expected %0h actual %0h", name, exp, act);
		$display("test failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic halt_with_error(input string msg);
		$display("ERROR %s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic model_resident(input logic [`CACHE_ADDR_W-1:0] a);
		foreach (recent[i])
			if (recent[i] == a)
				return 1'b1;
		return 1'b0;
	endfunction

	// Move to MRU, evicting the LRU line once all ways are full
	function automatic void model_touch(input logic [`CACHE_ADDR_W-1:0] a);
		int idx = -1;
		foreach (recent[i])
			if (recent[i] == a)
				idx = i;
		if (idx >= 0)
			recent.delete(idx);           // Re-hit refreshes recency
		else if (recent.size() == `CACHE_WAYS)
			void'(recent.pop_front());    // Oldest line leaves
		recent.push_back(a);
	endfunction

	//////////////////////////////
	// Host handshake
	//////////////////////////////

	task automatic wait_ack_rise(input string name, output int n);
		n = 0;
		while (ack !== 1'b1) begin
			@(negedge clk); // Outputs settled here
			n++;
			if (n > ACK_TIMEOUT)
				halt_with_error({name, ": ack never rose"});
		end
	endtask

	task automatic wait_ack_fall(input string name);
		int n;
		n = 0;
		while (ack !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > ACK_TIMEOUT)
				halt_with_error({name, ": ack never fell after req dropped"});
		end
	endtask

	// One full four-phase access, checked against the model
	task automatic access(input string name, input cache_op_t kind,
		input logic [`CACHE_ADDR_W-1:0] a, input logic [`CACHE_DATA_W-1:0] d);
		logic                     exp_hit;
		logic [`CACHE_DATA_W-1:0] exp_data;
		int                       hold;
		int                       cycles;
		exp_hit  = model_resident(a);
		exp_data = model_mem[a];
		model_touch(a);
		if (kind == OP_WRITE)
			model_mem[a] = d;
		hold = $urandom_range(0, 2); // Extra cycles the host sits on req
		@(posedge clk);
		req   <= 1'b1;
		op    <= kind;
		addr  <= a;
		wdata <= d;
		wait_ack_rise(name, cycles);
		assert (hit === exp_hit) else report_mismatch({name, " hit"}, 32'(exp_hit), 32'(hit));
		if (kind == OP_READ)
			assert (rdata === exp_data)
				else report_mismatch({name, " rdata"}, 32'(exp_data), 32'(rdata));
		if (exp_hit)
			assert (cycles == HIT_CYCLES)
				else report_mismatch({name, " hit latency"}, HIT_CYCLES, cycles);
		repeat (hold) begin
			@(negedge clk);
			assert (ack === 1'b1) else report_mismatch({name, " ack hold"}, 1, 32'(ack));
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		assert (ack === 1'b1) else report_mismatch({name, " ack at req fall"}, 1, 32'(ack));
		wait_ack_fall(name);
	endtask

	// ack may only change state in step with req
	always @(negedge clk) begin
		if (arst_n === 1'b1) begin
			assert (!(ack && !ack_prev && !req)) else halt_with_error("ack rose while req was low");
			assert (!(!ack && ack_prev && req)) else halt_with_error("ack fell while req was high");
		end
		ack_prev = ack;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [`CACHE_ADDR_W-1:0] a;
		cache_op_t                kind;
		void'($urandom(32'hf107b1ab));
		arst_n <= 1'b0;
		req    <= 1'b0;
		op     <= OP_READ;
		addr   <= '0;
		wdata  <= '0;
		foreach (model_mem[i])
			model_mem[i] = '0; // RAM clears on reset
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		assert (ack === 1'b0) else report_mismatch("reset ack", 0, 32'(ack));

		// Cold reads, all zero and all misses
		for (int i = 0; i < 6; i++)
			access("reset_read", OP_READ, 8'($urandom_range(0, 255)), '0);

		// Mixed traffic over 16 lines, four times the cache size
		for (int i = 0; i < 300; i++) begin
			a    = 8'(($urandom_range(0, 15) << 4) | 9);
			kind = ($urandom_range(0, 1) == 1) ? OP_WRITE : OP_READ;
			access("random_mix", kind, a, 8'($urandom_range(0, 255)));
		end

		// Six writes push the first two out dirty
		for (int i = 0; i < 6; i++)
			access("evict_writeback", OP_WRITE, 8'(8'hc0 + i), 8'($urandom_range(0, 255)));
		access("evict_writeback", OP_READ, 8'hc0, '0);
		access("evict_writeback", OP_READ, 8'hc1, '0);

		repeat (4) @(posedge clk);
		$display("test passed");
		$finish;
	end

endmodule
